// File: filelist.f
verilog/pcie_ctrl_pkg.sv
verilog/link_start_seq.sv
verilog/tlp_bar_demux.sv
verilog/tlp_hdr_dec.sv
verilog/cpl_gen.sv
verilog/tx_cpl_arb.sv
verilog/pcie_ctrl_top.sv
verification/tb_pcie_ctrl.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_pcie_ctrl \
    -f filelist.f \
    --Mdir obj_dir -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "TEST RESULT: FAIL" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// File: verification/tb_pcie_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module tb_pcie_ctrl import pcie_ctrl_pkg::*; ();

    localparam int CLK_HALF  = 50;
    localparam int DRIVE_DLY = 10;

    // start-up counter bit positions for simulation
    localparam int SIM_SYS_RST_DLY = 2;
    localparam int SIM_PERST_DLY   = 3;
    localparam int SIM_PCIE_DLY    = 4;
    localparam int SIM_RUN_DLY     = 3;

    // run counter values at perst done and at link start
    localparam int PERST_DONE_CYC = (1 << SIM_SYS_RST_DLY) + (1 << SIM_PERST_DLY);
    localparam int LINK_START_CYC = (1 << SIM_SYS_RST_DLY) + (1 << SIM_PCIE_DLY);

    // transaction counts per test phase
    localparam int N_WR    = 12;
    localparam int N_RD    = 4;
    localparam int N_PAIR  = 4;
    localparam int N_NOOP  = 10;
    localparam int N_HALT  = 8;

    localparam int STARTUP_CYC   = 64;
    localparam int CYC_PER_TRANS = 40;
    localparam int TRANS_NUM     = N_WR + N_RD + 4 * N_PAIR + N_NOOP + 2 * REG_NUM
                                   + 3 * N_HALT;
    localparam int TIMEOUT_CYC   = STARTUP_CYC + TRANS_NUM * CYC_PER_TRANS;

    localparam logic [BARDEC_W-1:0] HIT_BAR0 = 6'b000001;
    localparam logic [BARDEC_W-1:0] HIT_BAR1 = 6'b000010;
    localparam logic [BARDEC_W-1:0] HIT_BAR4 = 6'b010000;

    logic                  cfg_clk;
    logic                  rstn;
    logic                  pcie_rstn;
    logic                  linkup;
    logic                  tx_wait;
    logic                  rx_sop;
    logic                  rx_eop;
    logic [TLP_DW_NUM-1:0] rx_valid;
    logic [TLP_DATA_W-1:0] rx_data;
    logic [BARDEC_W-1:0]   rx_bardec;
    logic [31:0]           tx_cpl_credits;
    logic [BUSDEV_W-1:0]   cfg_busdev;
    logic                  tx_sop;
    logic                  tx_eop;
    logic [TLP_DW_NUM-1:0] tx_valid;
    logic [TLP_DATA_W-1:0] tx_data;
    logic [3:0]            led;

    // reference register banks, 0 is bar1 and 1 is bar4
    logic [REG_W-1:0] model [2][REG_NUM];
    logic [7:0]       exp_tag [$];
    logic [127:0]     exp_cpl [$];

    logic [31:0] lfsr;
    logic        rand_halt;
    logic        halt_d1 = 1'b0;
    logic        halt_d2 = 1'b0;
    int          cyc_cnt = 0;
    int          run_ref = 0;
    int          err_val_cnt = 0;
    int          err_other_cnt = 0;
    int          cpl_cnt = 0;

    pcie_ctrl_top #(
        .SYS_RST_DLY (SIM_SYS_RST_DLY),
        .PERST_DLY   (SIM_PERST_DLY),
        .PCIE_DLY    (SIM_PCIE_DLY),
        .RUN_DLY     (SIM_RUN_DLY)
    ) uut (
        .cfg_clk          (cfg_clk),
        .rstn             (rstn),
        .pcie_rstn_i      (pcie_rstn),
        .linkup_i         (linkup),
        .tx_wait_i        (tx_wait),
        .rx_sop_i         (rx_sop),
        .rx_eop_i         (rx_eop),
        .rx_valid_i       (rx_valid),
        .rx_data_i        (rx_data),
        .rx_bardec_i      (rx_bardec),
        .tx_cpl_credits_i (tx_cpl_credits),
        .cfg_busdev_i     (cfg_busdev),
        .tx_sop_o         (tx_sop),
        .tx_eop_o         (tx_eop),
        .tx_valid_o       (tx_valid),
        .tx_data_o        (tx_data),
        .led_o            (led)
    );

    initial begin
        cfg_clk = 1'b0;
        forever #CLK_HALF cfg_clk = ~cfg_clk;
    end

    // fibonacci lfsr x^32+x^22+x^2+x+1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp) begin
            err_val_cnt++;
            $display("ERR %s got %0h exp %0h", name, got, exp);
        end
    endtask

    task automatic finish_run(input logic timed_out);
        $display("run ended: %0d value errors, %0d other errors, %0d completions checked",
                 err_val_cnt, err_other_cnt, cpl_cnt);
        if (!timed_out && err_val_cnt == 0 && err_other_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    // one clock, then idle rx and fresh halt pattern
    task automatic step();
        logic [31:0] r;
        @(posedge cfg_clk);
        #DRIVE_DLY;
        rx_sop    = 1'b0;
        rx_eop    = 1'b0;
        rx_valid  = '0;
        rx_bardec = '0;
        if (rand_halt) begin
            r              = rand_bits(6);
            tx_wait        = (r[1:0] == 2'b00);
            tx_cpl_credits = rand_bits(31);
            tx_cpl_credits[CREDIT_OK_BIT] = (r[3:2] != 2'b00);
            linkup         = (r[5:4] != 2'b00);
        end
    endtask

    task automatic send_req(input logic [BARDEC_W-1:0] bar, input logic [2:0] fmt,
                            input logic [4:0] typ, input logic [9:0] len,
                            input logic [15:0] req_id, input logic [7:0] tag,
                            input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [7:0] valid);
        step();
        rx_sop    = 1'b1;
        rx_eop    = 1'b1;
        rx_valid  = valid;
        rx_bardec = bar;
        // dw0 fmt/type/len, dw1 req id/tag/byte enables, dw2 address, dw3 payload
        rx_data   = {128'd0, wdata, addr, req_id, tag, 8'hFF, fmt, typ, 14'd0, len};
    endtask

    task automatic write_reg(input int bank, input logic [3:0] idx, input logic [31:0] val);
        logic [31:0] addr;
        logic [15:0] rid;
        logic [7:0]  tag;
        addr      = rand_bits(32);
        addr[5:2] = idx;
        addr[1:0] = 2'b00;
        rid       = 16'(rand_bits(16));
        tag       = 8'(rand_bits(8));
        send_req((bank == 0) ? HIT_BAR1 : HIT_BAR4, FMT_MWR32, TYP_MEM, 10'd1,
                 rid, tag, addr, val, 8'h0F);
        model[bank][idx] = val;
    endtask

    task automatic issue_read(input int bank, input logic [3:0] idx);
        logic [31:0] addr;
        logic [15:0] rid;
        logic [7:0]  tag;
        addr      = rand_bits(32);
        addr[5:2] = idx;
        addr[1:0] = 2'b00;
        rid       = 16'(rand_bits(16));
        tag       = 8'(rand_bits(8));
        // low tag bit keeps the two banks apart
        tag[0]    = (bank != 0);
        exp_tag.push_back(tag);
        exp_cpl.push_back({model[bank][idx],
                           rid, tag, 1'b0, addr[6:2], 2'b00,
                           cfg_busdev, 3'b000, 3'b000, 1'b0, 12'd4,
                           FMT_CPLD, TYP_CPL, 14'd0, 10'd1});
        send_req((bank == 0) ? HIT_BAR1 : HIT_BAR4, FMT_MRD32, TYP_MEM, 10'd1,
                 rid, tag, addr, 32'd0, 8'h07);
    endtask

    // requests the decoder has to discard
    task automatic send_noop(input int kind);
        logic [31:0] addr;
        logic [31:0] val;
        addr      = rand_bits(32);
        addr[1:0] = 2'b00;
        val       = rand_bits(32);
        case (kind)
            0: send_req(HIT_BAR0, FMT_MWR32, TYP_MEM, 10'd1, 16'h0100, 8'h20, addr, val, 8'h0F);
            1: send_req(HIT_BAR1, FMT_MRD32, TYP_MEM, 10'd2, 16'h0100, 8'h22, addr, val, 8'h07);
            2: send_req(HIT_BAR4, FMT_MWR32, TYP_MEM, 10'd2, 16'h0100, 8'h24, addr, val, 8'h1F);
            3: send_req(HIT_BAR1, FMT_MWR32, 5'b00010, 10'd1, 16'h0100, 8'h26, addr, val, 8'h0F);
            default: send_req(HIT_BAR4, 3'b001, TYP_MEM, 10'd1, 16'h0100, 8'h28, addr, val,
                              8'h0F);
        endcase
    endtask

    task automatic wait_cpl();
        while (exp_tag.size() != 0) begin
            step();
        end
    endtask

    task automatic take_cpl();
        int hit;
        hit = -1;
        for (int i = 0; i < exp_tag.size(); i++) begin
            if (hit < 0 && exp_tag[i] == tx_data[79:72]) begin
                hit = i;
            end
        end
        if (hit < 0) begin
            err_other_cnt++;
            $display("unexpected completion with tag %0h at cycle %0d", tx_data[79:72], cyc_cnt);
        end else begin
            check("tx_data_o dw0", 128'(tx_data[31:0]), 128'(exp_cpl[hit][31:0]));
            check("tx_data_o dw1", 128'(tx_data[63:32]), 128'(exp_cpl[hit][63:32]));
            check("tx_data_o dw2", 128'(tx_data[95:64]), 128'(exp_cpl[hit][95:64]));
            check("tx_data_o dw3", 128'(tx_data[127:96]), 128'(exp_cpl[hit][127:96]));
            check("tx_data_o upper", tx_data[255:128], 128'd0);
            check("tx_valid_o", 128'(tx_valid), 128'h0F);
            check("tx_eop_o", 128'(tx_eop), 128'd1);
            exp_tag.delete(hit);
            exp_cpl.delete(hit);
            cpl_cnt++;
        end
    endtask

    // free-running run counter, counts once board reset and PERST# are released
    always @(posedge cfg_clk) begin
        if (rstn && pcie_rstn) begin
            run_ref <= run_ref + 1;
        end
    end

    // halt seen on the grant edge, two edges before tx_sop_o
    always @(posedge cfg_clk) begin
        halt_d1 <= tx_wait | ~tx_cpl_credits[CREDIT_OK_BIT] | ~linkup;
        halt_d2 <= halt_d1;
    end

    always @(negedge cfg_clk) begin
        if (tx_sop) begin
            if (halt_d2) begin
                err_other_cnt++;
                $display("completion sent although the path was halted, cycle %0d", cyc_cnt);
            end
            take_cpl();
        end
    end

    always @(posedge cfg_clk) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt == TIMEOUT_CYC) begin
            $display("timeout after %0d cycles with %0d completions still missing",
                     cyc_cnt, exp_tag.size());
            finish_run(1'b1);
        end
    end

    initial begin
        logic [3:0]  idx;
        logic [31:0] val;
        int          start_cyc;
        lfsr           = 32'h367e;
        rstn           = 1'b0;
        pcie_rstn      = 1'b1;
        linkup         = 1'b0;
        tx_wait        = 1'b0;
        rx_sop         = 1'b0;
        rx_eop         = 1'b0;
        rx_valid       = '0;
        rx_data        = '0;
        rx_bardec      = '0;
        rand_halt      = 1'b0;
        tx_cpl_credits = 32'h8000_0040;
        cfg_busdev     = 13'(rand_bits(13));
        start_cyc      = 0;
        for (int i = 0; i < REG_NUM; i++) begin
            model[0][i] = '0;
            model[1][i] = '0;
        end
        repeat (3) @(posedge cfg_clk);
        #DRIVE_DLY;
        rstn = 1'b1;

        // startup: quiet tx port until link start
        step();
        while (led[2] == 1'b1) begin
            check("tx_sop_o", 128'(tx_sop), 128'd0);
            check("tx_valid_o", 128'(tx_valid), 128'd0);
            check("led_o[3]", 128'(led[3]), 128'(!linkup));
            check("led_o[1]", 128'(led[1]), 128'(run_ref < PERST_DONE_CYC));
            check("led_o[0]", 128'(led[0]), 128'(!run_ref[SIM_RUN_DLY]));
            start_cyc++;
            step();
        end
        if (start_cyc == 0) begin
            err_other_cnt++;
            $display("led_o[2] never showed the link as not yet started");
        end
        check("link start cycle", 128'(run_ref), 128'(LINK_START_CYC));
        check("led_o[1]", 128'(led[1]), 128'd0);
        linkup = 1'b1;
        step();
        step();
        check("led_o[3]", 128'(led[3]), 128'd0);
        linkup = 1'b0;
        step();
        step();
        check("led_o[3]", 128'(led[3]), 128'd1);
        linkup = 1'b1;
        step();

        // random writes then reads on bar1
        for (int n = 0; n < N_WR; n++) begin
            idx = 4'(rand_bits(4));
            val = rand_bits(32);
            write_reg(0, idx, val);
        end
        for (int n = 0; n < N_RD; n++) begin
            idx = 4'(rand_bits(4));
            issue_read(0, idx);
            wait_cpl();
        end

        // same offset, different data in both banks
        for (int n = 0; n < N_PAIR; n++) begin
            idx = 4'(rand_bits(4));
            val = rand_bits(32);
            write_reg(0, idx, val);
            write_reg(1, idx, ~val);
            issue_read(0, idx);
            issue_read(1, idx);
            wait_cpl();
        end

        // ignored requests, then full readback of both banks
        for (int n = 0; n < N_NOOP; n++) begin
            send_noop(n % 5);
        end
        repeat (12) step();
        for (int i = 0; i < REG_NUM; i++) begin
            issue_read(0, 4'(i));
            issue_read(1, 4'(i));
            wait_cpl();
        end

        // random halts on the completion path
        rand_halt = 1'b1;
        for (int n = 0; n < N_HALT; n++) begin
            idx = 4'(rand_bits(4));
            val = rand_bits(32);
            write_reg(n % 2, idx, val);
            issue_read(0, idx);
            idx = 4'(rand_bits(4));
            issue_read(1, idx);
            wait_cpl();
        end
        rand_halt = 1'b0;
        step();
        tx_wait = 1'b0;
        tx_cpl_credits[CREDIT_OK_BIT] = 1'b1;
        linkup = 1'b1;
        repeat (8) step();
        finish_run(1'b0);
    end

endmodule

`default_nettype wire

// File: verilog/cpl_gen.sv
`timescale 1ns/100ps
`default_nettype none

module cpl_gen import pcie_ctrl_pkg::*; (
    input  logic                  cfg_clk,
    input  logic                  rstn,
    input  logic [BUSDEV_W-1:0]   cfg_busdev_i,
    input  logic                  cmd_en_i,
    input  logic                  is_write_i,
    input  logic [REG_IDX_W-1:0]  reg_idx_i,
    input  logic [REQ_ID_W-1:0]   req_id_i,
    input  logic [TAG_W-1:0]      tag_i,
    input  logic [6:0]            lower_addr_i,
    input  logic [REG_W-1:0]      wr_data_i,
    input  logic                  cpl_grant_i,
    output logic                  cpl_req_o,
    output logic                  cpl_sop_o,
    output logic                  cpl_eop_o,
    output logic [TLP_DW_NUM-1:0] cpl_valid_o,
    output logic [TLP_DATA_W-1:0] cpl_data_o
);

    logic [REG_W-1:0] regs [REG_NUM];
    logic             rd_take;
    logic [31:0]      cpl_dw0;
    logic [31:0]      cpl_dw1;
    logic [31:0]      cpl_dw2;

    // only one completion in flight per bank
    assign rd_take = cmd_en_i & ~is_write_i & ~cpl_req_o;

    // cpld header, length 1
    assign cpl_dw0 = {FMT_CPLD, TYP_CPL, {(32 - FMT_W - TYP_W - LEN_W){1'b0}}, LEN_W'(1)};
    // completer id, status ok, byte count 4
    assign cpl_dw1 = {cfg_busdev_i, 3'b000, 3'b000, 1'b0, 12'd4};
    assign cpl_dw2 = {req_id_i, tag_i, 1'b0, lower_addr_i};

    always_ff @(posedge cfg_clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (cmd_en_i && is_write_i) begin
            regs[reg_idx_i] <= wr_data_i;
        end
    end

    always_ff @(posedge cfg_clk or negedge rstn) begin
        if (!rstn) begin
            cpl_req_o <= 1'b0;
        end else if (cpl_grant_i) begin
            cpl_req_o <= 1'b0;
        end else if (rd_take) begin
            cpl_req_o <= 1'b1;
        end
    end

    // register value is sampled when the read command arrives
    always_ff @(posedge cfg_clk) begin
        if (rd_take) begin
            cpl_data_o <= {{(TLP_DATA_W - 128){1'b0}},
                           regs[reg_idx_i], cpl_dw2, cpl_dw1, cpl_dw0};
        end
    end

    // single-beat tlp, four header+data dwords
    assign cpl_sop_o   = cpl_req_o;
    assign cpl_eop_o   = cpl_req_o;
    assign cpl_valid_o = cpl_req_o ? {{(TLP_DW_NUM - 4){1'b0}}, 4'hF} : '0;

    a_grant_needs_req: assert property (@(posedge cfg_clk) disable iff (!rstn)
        cpl_grant_i |-> cpl_req_o)
        else $error("completion grant without a pending request");

    a_read_dropped: assert property (@(posedge cfg_clk) disable iff (!rstn)
        (cmd_en_i && !is_write_i) |-> !cpl_req_o)
        else $error("read dropped, completion still pending");

endmodule

`default_nettype wire

// File: verilog/link_start_seq.sv
`timescale 1ns/100ps
`default_nettype none

module link_start_seq import pcie_ctrl_pkg::*; #(
    parameter int SYS_RST_DLY = SYS_RST_DLY_DEF,
    parameter int PERST_DLY   = PERST_DLY_DEF,
    parameter int PCIE_DLY    = PCIE_DLY_DEF,
    parameter int RUN_DLY     = RUN_DLY_DEF
) (
    input  logic       cfg_clk,
    input  logic       rstn,
    input  logic       pcie_rstn_i,
    input  logic       linkup_i,
    output logic       link_start_o,
    output logic [3:0] led_o
);

    logic                 ext_rstn;
    logic                 sys_rstn;
    logic [SYS_RST_DLY:0] sys_rst_cnt;
    logic [PERST_DLY:0]   perst_cnt;
    logic [PCIE_DLY:0]    pcie_st_cnt;
    logic [RUN_DLY:0]     run_cnt;
    logic                 linkup_q;

    // either the board reset or PERST# restarts the whole sequence
    assign ext_rstn = rstn & pcie_rstn_i;

    always_ff @(posedge cfg_clk or negedge ext_rstn) begin
        if (!ext_rstn) begin
            sys_rst_cnt <= '0;
            run_cnt     <= '0;
            linkup_q    <= 1'b0;
        end else begin
            if (!sys_rst_cnt[SYS_RST_DLY]) begin
                sys_rst_cnt <= sys_rst_cnt + 1'b1;
            end
            run_cnt  <= run_cnt + 1'b1;
            linkup_q <= linkup_i;
        end
    end

    // internal reset releases once the stretch counter saturates
    assign sys_rstn = sys_rst_cnt[SYS_RST_DLY];

    always_ff @(posedge cfg_clk or negedge sys_rstn) begin
        if (!sys_rstn) begin
            perst_cnt   <= '0;
            pcie_st_cnt <= '0;
        end else begin
            if (!perst_cnt[PERST_DLY]) begin
                perst_cnt <= perst_cnt + 1'b1;
            end
            if (!pcie_st_cnt[PCIE_DLY]) begin
                pcie_st_cnt <= pcie_st_cnt + 1'b1;
            end
        end
    end

    assign link_start_o = pcie_st_cnt[PCIE_DLY];

    // leds are active low
    assign led_o[0] = ~run_cnt[RUN_DLY];
    assign led_o[1] = ~perst_cnt[PERST_DLY];
    assign led_o[2] = ~link_start_o;
    assign led_o[3] = ~linkup_q;

endmodule

`default_nettype wire

// File: verilog/pcie_ctrl_pkg.sv
`default_nettype none

package pcie_ctrl_pkg;

    // transaction-layer beat
    localparam int TLP_DATA_W = 256;
    localparam int TLP_DW_NUM = 8;

    // bar hit vector from the core
    localparam int BARDEC_W     = 6;
    localparam int BAR_DMA_CTRL = 1;
    localparam int BAR_MEM_CTRL = 4;

    localparam int BUSDEV_W = 13;

    // header field widths
    localparam int FMT_W    = 3;
    localparam int TYP_W    = 5;
    localparam int LEN_W    = 10;
    localparam int REQ_ID_W = 16;
    localparam int TAG_W    = 8;

    // fmt/type codes, 3 dword header
    localparam logic [FMT_W-1:0] FMT_MRD32 = 3'b000;
    localparam logic [FMT_W-1:0] FMT_MWR32 = 3'b010;
    localparam logic [FMT_W-1:0] FMT_CPLD  = 3'b010;
    localparam logic [TYP_W-1:0] TYP_MEM   = 5'b00000;
    localparam logic [TYP_W-1:0] TYP_CPL   = 5'b01010;

    // completer register banks
    localparam int REG_NUM     = 16;
    localparam int REG_IDX_W   = 4;
    localparam int REG_W       = 32;
    localparam int CPL_SRC_NUM = 2;

    // start-up counter bit positions
    localparam int SYS_RST_DLY_DEF = 20;
    localparam int PERST_DLY_DEF   = 25;
    localparam int PCIE_DLY_DEF    = 8;
    localparam int RUN_DLY_DEF     = 23;

    localparam int CREDIT_OK_BIT = 31;

endpackage

`default_nettype wire

// File: verilog/pcie_ctrl_top.sv
`timescale 1ns/100ps
`default_nettype none

module pcie_ctrl_top import pcie_ctrl_pkg::*; #(
    parameter int SYS_RST_DLY = SYS_RST_DLY_DEF,
    parameter int PERST_DLY   = PERST_DLY_DEF,
    parameter int PCIE_DLY    = PCIE_DLY_DEF,
    parameter int RUN_DLY     = RUN_DLY_DEF
) (
    input  logic                  cfg_clk,
    input  logic                  rstn,
    input  logic                  pcie_rstn_i,
    input  logic                  linkup_i,
    input  logic                  tx_wait_i,
    input  logic                  rx_sop_i,
    input  logic                  rx_eop_i,
    input  logic [TLP_DW_NUM-1:0] rx_valid_i,
    input  logic [TLP_DATA_W-1:0] rx_data_i,
    input  logic [BARDEC_W-1:0]   rx_bardec_i,
    input  logic [31:0]           tx_cpl_credits_i,
    input  logic [BUSDEV_W-1:0]   cfg_busdev_i,
    output logic                  tx_sop_o,
    output logic                  tx_eop_o,
    output logic [TLP_DW_NUM-1:0] tx_valid_o,
    output logic [TLP_DATA_W-1:0] tx_data_o,
    output logic [3:0]            led_o
);

    logic                   link_start;
    logic                   ctrl_sop, ctrl_eop, mem_sop, mem_eop;
    logic [TLP_DW_NUM-1:0]  ctrl_valid, mem_valid;
    logic [TLP_DATA_W-1:0]  ctrl_data, mem_data;
    logic                   ctrl_cmd_en, ctrl_is_wr, mem_cmd_en, mem_is_wr;
    logic [REG_IDX_W-1:0]   ctrl_idx, mem_idx;
    logic [REQ_ID_W-1:0]    ctrl_req_id, mem_req_id;
    logic [TAG_W-1:0]       ctrl_tag, mem_tag;
    logic [6:0]             ctrl_laddr, mem_laddr;
    logic [REG_W-1:0]       ctrl_wdata, mem_wdata;
    logic                   ctrl_cpl_req, ctrl_cpl_sop, ctrl_cpl_eop;
    logic                   mem_cpl_req, mem_cpl_sop, mem_cpl_eop;
    logic [TLP_DW_NUM-1:0]  ctrl_cpl_valid, mem_cpl_valid;
    logic [TLP_DATA_W-1:0]  ctrl_cpl_data, mem_cpl_data;
    logic [CPL_SRC_NUM-1:0] cpl_grant;

    link_start_seq #(
        .SYS_RST_DLY (SYS_RST_DLY),
        .PERST_DLY   (PERST_DLY),
        .PCIE_DLY    (PCIE_DLY),
        .RUN_DLY     (RUN_DLY)
    ) u_link_start_seq (
        .cfg_clk      (cfg_clk),
        .rstn         (rstn),
        .pcie_rstn_i  (pcie_rstn_i),
        .linkup_i     (linkup_i),
        .link_start_o (link_start),
        .led_o        (led_o)
    );

    // everything downstream stays in reset until link start
    tlp_bar_demux u_bar_demux (
        .cfg_clk (cfg_clk), .rstn (link_start),
        .rx_sop_i (rx_sop_i), .rx_eop_i (rx_eop_i), .rx_valid_i (rx_valid_i),
        .rx_data_i (rx_data_i), .rx_bardec_i (rx_bardec_i),
        .ctrl_sop_o (ctrl_sop), .ctrl_eop_o (ctrl_eop),
        .ctrl_valid_o (ctrl_valid), .ctrl_data_o (ctrl_data),
        .mem_sop_o (mem_sop), .mem_eop_o (mem_eop),
        .mem_valid_o (mem_valid), .mem_data_o (mem_data)
    );

    // bar1, dma control bank
    tlp_hdr_dec u_ctrl_dec (
        .cfg_clk (cfg_clk), .rstn (link_start),
        .sop_i (ctrl_sop), .eop_i (ctrl_eop), .valid_i (ctrl_valid), .data_i (ctrl_data),
        .cmd_en_o (ctrl_cmd_en), .is_write_o (ctrl_is_wr), .reg_idx_o (ctrl_idx),
        .req_id_o (ctrl_req_id), .tag_o (ctrl_tag), .lower_addr_o (ctrl_laddr),
        .wr_data_o (ctrl_wdata)
    );

    cpl_gen u_ctrl_cpl (
        .cfg_clk (cfg_clk), .rstn (link_start), .cfg_busdev_i (cfg_busdev_i),
        .cmd_en_i (ctrl_cmd_en), .is_write_i (ctrl_is_wr), .reg_idx_i (ctrl_idx),
        .req_id_i (ctrl_req_id), .tag_i (ctrl_tag), .lower_addr_i (ctrl_laddr),
        .wr_data_i (ctrl_wdata), .cpl_grant_i (cpl_grant[0]),
        .cpl_req_o (ctrl_cpl_req), .cpl_sop_o (ctrl_cpl_sop), .cpl_eop_o (ctrl_cpl_eop),
        .cpl_valid_o (ctrl_cpl_valid), .cpl_data_o (ctrl_cpl_data)
    );

    // bar4, memory control bank
    tlp_hdr_dec u_mem_dec (
        .cfg_clk (cfg_clk), .rstn (link_start),
        .sop_i (mem_sop), .eop_i (mem_eop), .valid_i (mem_valid), .data_i (mem_data),
        .cmd_en_o (mem_cmd_en), .is_write_o (mem_is_wr), .reg_idx_o (mem_idx),
        .req_id_o (mem_req_id), .tag_o (mem_tag), .lower_addr_o (mem_laddr),
        .wr_data_o (mem_wdata)
    );

    cpl_gen u_mem_cpl (
        .cfg_clk (cfg_clk), .rstn (link_start), .cfg_busdev_i (cfg_busdev_i),
        .cmd_en_i (mem_cmd_en), .is_write_i (mem_is_wr), .reg_idx_i (mem_idx),
        .req_id_i (mem_req_id), .tag_i (mem_tag), .lower_addr_i (mem_laddr),
        .wr_data_i (mem_wdata), .cpl_grant_i (cpl_grant[1]),
        .cpl_req_o (mem_cpl_req), .cpl_sop_o (mem_cpl_sop), .cpl_eop_o (mem_cpl_eop),
        .cpl_valid_o (mem_cpl_valid), .cpl_data_o (mem_cpl_data)
    );

    // source 0 is bar1, source 1 is bar4
    tx_cpl_arb u_cpl_arb (
        .cfg_clk          (cfg_clk),
        .rstn             (link_start),
        .tx_wait_i        (tx_wait_i),
        .linkup_i         (linkup_i),
        .tx_cpl_credits_i (tx_cpl_credits_i),
        .cpl_req_i        ({mem_cpl_req, ctrl_cpl_req}),
        .cpl_sop_i        ({mem_cpl_sop, ctrl_cpl_sop}),
        .cpl_eop_i        ({mem_cpl_eop, ctrl_cpl_eop}),
        .cpl_valid_i      ({mem_cpl_valid, ctrl_cpl_valid}),
        .cpl_data_i       ({mem_cpl_data, ctrl_cpl_data}),
        .cpl_grant_o      (cpl_grant),
        .tx_sop_o         (tx_sop_o),
        .tx_eop_o         (tx_eop_o),
        .tx_valid_o       (tx_valid_o),
        .tx_data_o        (tx_data_o)
    );

endmodule

`default_nettype wire

// File: verilog/tlp_bar_demux.sv
`timescale 1ns/100ps
`default_nettype none

module tlp_bar_demux import pcie_ctrl_pkg::*; (
    input  logic                  cfg_clk,
    input  logic                  rstn,
    input  logic                  rx_sop_i,
    input  logic                  rx_eop_i,
    input  logic [TLP_DW_NUM-1:0] rx_valid_i,
    input  logic [TLP_DATA_W-1:0] rx_data_i,
    input  logic [BARDEC_W-1:0]   rx_bardec_i,
    output logic                  ctrl_sop_o,
    output logic                  ctrl_eop_o,
    output logic [TLP_DW_NUM-1:0] ctrl_valid_o,
    output logic [TLP_DATA_W-1:0] ctrl_data_o,
    output logic                  mem_sop_o,
    output logic                  mem_eop_o,
    output logic [TLP_DW_NUM-1:0] mem_valid_o,
    output logic [TLP_DATA_W-1:0] mem_data_o
);

    logic                  beat;
    logic                  ctrl_sel;
    logic                  mem_sel;
    logic                  ctrl_sel_q;
    logic                  mem_sel_q;
    logic [TLP_DATA_W-1:0] data_q;

    assign beat = |rx_valid_i;

    // bar is only valid on sop, later beats reuse the captured one
    assign ctrl_sel = beat & (rx_sop_i ? rx_bardec_i[BAR_DMA_CTRL] : ctrl_sel_q);
    assign mem_sel  = beat & (rx_sop_i ? rx_bardec_i[BAR_MEM_CTRL] : mem_sel_q);

    always_ff @(posedge cfg_clk or negedge rstn) begin
        if (!rstn) begin
            ctrl_sel_q   <= 1'b0;
            mem_sel_q    <= 1'b0;
            ctrl_sop_o   <= 1'b0;
            ctrl_eop_o   <= 1'b0;
            ctrl_valid_o <= '0;
            mem_sop_o    <= 1'b0;
            mem_eop_o    <= 1'b0;
            mem_valid_o  <= '0;
        end else begin
            if (beat && rx_sop_i) begin
                ctrl_sel_q <= rx_bardec_i[BAR_DMA_CTRL];
                mem_sel_q  <= rx_bardec_i[BAR_MEM_CTRL];
            end
            ctrl_sop_o   <= ctrl_sel & rx_sop_i;
            ctrl_eop_o   <= ctrl_sel & rx_eop_i;
            ctrl_valid_o <= ctrl_sel ? rx_valid_i : '0;
            mem_sop_o    <= mem_sel & rx_sop_i;
            mem_eop_o    <= mem_sel & rx_eop_i;
            mem_valid_o  <= mem_sel ? rx_valid_i : '0;
        end
    end

    // one data register feeds both ports, the valid mask qualifies it
    always_ff @(posedge cfg_clk) begin
        if (beat) begin
            data_q <= rx_data_i;
        end
    end

    assign ctrl_data_o = data_q;
    assign mem_data_o  = data_q;

    a_sop_has_valid: assert property (@(posedge cfg_clk) disable iff (!rstn)
        rx_sop_i |-> (rx_valid_i != '0))
        else $error("sop beat from the core with an empty valid mask");

endmodule

`default_nettype wire

// File: verilog/tlp_hdr_dec.sv
`timescale 1ns/100ps
`default_nettype none

module tlp_hdr_dec import pcie_ctrl_pkg::*; (
    input  logic                  cfg_clk,
    input  logic                  rstn,
    input  logic                  sop_i,
    input  logic                  eop_i,
    input  logic [TLP_DW_NUM-1:0] valid_i,
    input  logic [TLP_DATA_W-1:0] data_i,
    output logic                  cmd_en_o,
    output logic                  is_write_o,
    output logic [REG_IDX_W-1:0]  reg_idx_o,
    output logic [REQ_ID_W-1:0]   req_id_o,
    output logic [TAG_W-1:0]      tag_o,
    output logic [6:0]            lower_addr_o,
    output logic [REG_W-1:0]      wr_data_o
);

    logic [31:0]      dw0;
    logic [31:0]      dw1;
    logic [31:0]      dw2;
    logic [31:0]      dw3;
    logic [FMT_W-1:0] fmt;
    logic [TYP_W-1:0] typ;
    logic [LEN_W-1:0] len;
    logic             is_rd;
    logic             is_wr;
    logic             hit;

    // dword 0 sits in the low 32 bits of the beat
    assign dw0 = data_i[31:0];
    assign dw1 = data_i[63:32];
    assign dw2 = data_i[95:64];
    assign dw3 = data_i[127:96];

    assign fmt = dw0[31:29];
    assign typ = dw0[28:24];
    assign len = dw0[LEN_W-1:0];

    // write needs the payload dword present
    assign is_rd = (fmt == FMT_MRD32) & valid_i[2];
    assign is_wr = (fmt == FMT_MWR32) & valid_i[3];

    // single beat, single dword, memory type only
    assign hit = sop_i & eop_i & (typ == TYP_MEM) & (len == LEN_W'(1)) & (is_rd | is_wr);

    always_ff @(posedge cfg_clk or negedge rstn) begin
        if (!rstn) begin
            cmd_en_o <= 1'b0;
        end else begin
            cmd_en_o <= hit;
        end
    end

    always_ff @(posedge cfg_clk) begin
        if (hit) begin
            is_write_o   <= is_wr;
            reg_idx_o    <= dw2[2 +: REG_IDX_W];
            req_id_o     <= dw1[31:16];
            tag_o        <= dw1[15:8];
            lower_addr_o <= {dw2[6:2], 2'b00};
            wr_data_o    <= dw3;
        end
    end

endmodule

`default_nettype wire

// File: verilog/tx_cpl_arb.sv
`timescale 1ns/100ps
`default_nettype none

module tx_cpl_arb import pcie_ctrl_pkg::*; (
    input  logic                              cfg_clk,
    input  logic                              rstn,
    input  logic                              tx_wait_i,
    input  logic                              linkup_i,
    input  logic [31:0]                       tx_cpl_credits_i,
    input  logic [CPL_SRC_NUM-1:0]            cpl_req_i,
    input  logic [CPL_SRC_NUM-1:0]            cpl_sop_i,
    input  logic [CPL_SRC_NUM-1:0]            cpl_eop_i,
    input  logic [CPL_SRC_NUM*TLP_DW_NUM-1:0] cpl_valid_i,
    input  logic [CPL_SRC_NUM*TLP_DATA_W-1:0] cpl_data_i,
    output logic [CPL_SRC_NUM-1:0]            cpl_grant_o,
    output logic                              tx_sop_o,
    output logic                              tx_eop_o,
    output logic [TLP_DW_NUM-1:0]             tx_valid_o,
    output logic [TLP_DATA_W-1:0]             tx_data_o
);

    logic                           halt;
    logic [CPL_SRC_NUM-1:0]         cand;
    logic [CPL_SRC_NUM-1:0]         grant_nxt;
    logic [$clog2(CPL_SRC_NUM)-1:0] nxt_idx;
    logic [$clog2(CPL_SRC_NUM)-1:0] win_idx;
    logic [$clog2(CPL_SRC_NUM)-1:0] last_q;

    assign halt = tx_wait_i | ~tx_cpl_credits_i[CREDIT_OK_BIT] | ~linkup_i;

    // a source already holding the grant drops its request next cycle
    assign cand = halt ? '0 : (cpl_req_i & ~cpl_grant_o);

    // search starts at the source after the last winner
    always_comb begin
        int unsigned idx;
        logic        found;
        grant_nxt = '0;
        nxt_idx   = '0;
        found     = 1'b0;
        for (int unsigned k = 1; k <= CPL_SRC_NUM; k++) begin
            idx = (last_q + k) % CPL_SRC_NUM;
            if (!found && cand[idx]) begin
                grant_nxt[idx] = 1'b1;
                nxt_idx        = idx[$clog2(CPL_SRC_NUM)-1:0];
                found          = 1'b1;
            end
        end
    end

    always_comb begin
        win_idx = '0;
        for (int k = 0; k < CPL_SRC_NUM; k++) begin
            if (cpl_grant_o[k]) begin
                win_idx = k[$clog2(CPL_SRC_NUM)-1:0];
            end
        end
    end

    always_ff @(posedge cfg_clk or negedge rstn) begin
        if (!rstn) begin
            cpl_grant_o <= '0;
            last_q      <= '0;
            tx_sop_o    <= 1'b0;
            tx_eop_o    <= 1'b0;
            tx_valid_o  <= '0;
        end else begin
            cpl_grant_o <= grant_nxt;
            if (|grant_nxt) begin
                last_q <= nxt_idx;
            end
            // beat is taken on the grant edge
            tx_sop_o   <= (|cpl_grant_o) & cpl_sop_i[win_idx];
            tx_eop_o   <= (|cpl_grant_o) & cpl_eop_i[win_idx];
            tx_valid_o <= (|cpl_grant_o) ? cpl_valid_i[win_idx*TLP_DW_NUM +: TLP_DW_NUM] : '0;
        end
    end

    always_ff @(posedge cfg_clk) begin
        if (|cpl_grant_o) begin
            tx_data_o <= cpl_data_i[win_idx*TLP_DATA_W +: TLP_DATA_W];
        end
    end

    // a granted source still presents its beat on the grant edge
    a_grant_onehot: assert property (@(posedge cfg_clk) disable iff (!rstn)
        $onehot0(cpl_grant_o) && ((cpl_grant_o & ~cpl_req_i) == '0))
        else $error("completion grant not one-hot or given to an idle source");

endmodule

`default_nettype wire
